// File: all.f
design/immu_pkg.sv
design/tlb_lookup_if.sv
design/tlb_array.sv
design/plru_tree.sv
design/refill_ctrl.sv
design/translate_stage.sv
design/immu.sv
bench/clk_rst_gen.sv
bench/immu_tb.sv

// File: bench/clk_rst_gen.sv
`timescale 1ns/1ps

module clk_rst_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: bench/immu_tb.sv
`timescale 1ns/1ps

module immu_tb
    import immu_pkg::*;
();

    localparam priv_t      priv_u         = 2'd0;
    localparam priv_t      priv_s         = 2'd1;
    localparam logic [3:0] mode_sv39      = 4'h8;
    // g, u, x
    localparam logic [2:0] flags_sx       = 3'b001;
    localparam logic [2:0] flags_ux       = 3'b011;
    localparam logic [2:0] flags_gx       = 3'b101;
    localparam logic [2:0] flags_nx       = 3'b000;
    localparam logic [1:0] miss_no        = 2'd0;
    localparam logic [1:0] miss_yes       = 2'd1;
    // outcome depends on the plru history
    localparam logic [1:0] miss_any       = 2'd2;
    localparam int         cycles_per_row = 200;

    typedef struct packed {
        priv_t      priv;
        logic [3:0] mode;
        asid_t      asid;
        vaddr_t     va;
        pte_t       pte;
        logic       pte_err;
        logic       sflush;
        logic [1:0] exp_miss;
        paddr_t     exp_pa;
        logic       exp_err;
    } fetch_row_t;

    logic        clk;
    logic        rst_n;
    priv_t       current_priv_status;
    logic [3:0]  satp_mode;
    asid_t       satp_asid;
    logic        flush_flag;
    logic        sflush_vma_valid;
    logic        immu_miss_valid;
    logic        immu_miss_ready;
    vaddr_t      miss_vaddr;
    logic        pte_valid;
    logic        pte_ready;
    pte_t        pte;
    logic        pte_error;
    logic        mmu_fifo_valid;
    logic        mmu_fifo_ready;
    vaddr_t      vaddr;
    logic        paddr_valid;
    logic        paddr_ready;
    paddr_t      paddr;
    logic        paddr_error;

    fetch_row_t  rows[$];
    int          pending_q[$];
    int          row_count;
    int          results_seen;
    int          any_misses;
    int unsigned seed;
    pte_t        resp_pte;
    logic        resp_err;

    clk_rst_gen clk_rst_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    immu immu_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .current_priv_status (current_priv_status),
        .satp_mode           (satp_mode),
        .satp_asid           (satp_asid),
        .flush_flag          (flush_flag),
        .sflush_vma_valid    (sflush_vma_valid),
        .immu_miss_valid     (immu_miss_valid),
        .immu_miss_ready     (immu_miss_ready),
        .miss_vaddr          (miss_vaddr),
        .pte_valid           (pte_valid),
        .pte_ready           (pte_ready),
        .pte                 (pte),
        .pte_error           (pte_error),
        .mmu_fifo_valid      (mmu_fifo_valid),
        .mmu_fifo_ready      (mmu_fifo_ready),
        .vaddr               (vaddr),
        .paddr_valid         (paddr_valid),
        .paddr_ready         (paddr_ready),
        .paddr               (paddr),
        .paddr_error         (paddr_error)
    );

    // **************************************************************************
    // reporting
    // **************************************************************************

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED time %0t signal %s got 0x%h expected 0x%h",
                               $time, name, got, exp));
        end
    endtask

    // **************************************************************************
    // stimulus table
    // **************************************************************************

    // the l2 answers with the current asid and the vpn of the fetch
    function automatic void add_row(input priv_t priv, input logic [3:0] mode,
                                    input asid_t asid, input vaddr_t va, input ppn_t ppn,
                                    input logic [2:0] gux, input logic pte_err,
                                    input logic sflush, input logic [1:0] exp_miss,
                                    input paddr_t exp_pa, input logic exp_err);
        fetch_row_t row;
        row.priv                              = priv;
        row.mode                              = mode;
        row.asid                              = asid;
        row.va                                = va;
        row.pte                               = '0;
        row.pte[pte_vpn_lsb +: $bits(vpn_t)]  = va[38:12];
        row.pte[pte_ppn_lsb +: $bits(ppn_t)]  = ppn;
        row.pte[pte_asid_lsb +: $bits(asid_t)] = asid;
        row.pte[pte_g_bit]                    = gux[2];
        row.pte[pte_u_bit]                    = gux[1];
        row.pte[pte_x_bit]                    = gux[0];
        row.pte_err                           = pte_err;
        row.sflush                            = sflush;
        row.exp_miss                          = exp_miss;
        row.exp_pa                            = exp_pa;
        row.exp_err                           = exp_err;
        rows.push_back(row);
    endfunction

    function automatic void build_table();
        // bypass
        add_row(priv_m, mode_sv39, 16'h1, 64'h8000_0000_0000_1234, 44'h0, flags_sx, 0, 0,
                miss_no, 64'h8000_0000_0000_1234, 0);
        add_row(priv_s, satp_mode_bare, 16'h1, 64'h40_0abc, 44'h0, flags_sx, 0, 0,
                miss_no, 64'h40_0abc, 0);
        add_row(priv_u, satp_mode_bare, 16'h1, 64'hffff_ffff_ffff_fff0, 44'h0, flags_sx, 0, 0,
                miss_no, 64'hffff_ffff_ffff_fff0, 0);
        // miss, refill, hit
        add_row(priv_s, mode_sv39, 16'h1, 64'h1_0100, 44'h0abcd, flags_sx, 0, 0,
                miss_yes, 64'h0abc_d100, 0);
        add_row(priv_s, mode_sv39, 16'h1, 64'h1_0ffc, 44'h0abcd, flags_sx, 0, 0,
                miss_no, 64'h0abc_dffc, 0);
        add_row(priv_s, mode_sv39, 16'h1, 64'h2_0000, 44'h12345, flags_sx, 0, 0,
                miss_yes, 64'h1234_5000, 0);
        add_row(priv_s, mode_sv39, 16'h1, 64'h1_0040, 44'h0abcd, flags_sx, 0, 0,
                miss_no, 64'h0abc_d040, 0);
        // asid and global
        add_row(priv_s, mode_sv39, 16'h2, 64'h1_0008, 44'h55555, flags_sx, 0, 0,
                miss_yes, 64'h5555_5008, 0);
        add_row(priv_s, mode_sv39, 16'h1, 64'h3_0010, 44'h77777, flags_gx, 0, 0,
                miss_yes, 64'h7777_7010, 0);
        add_row(priv_s, mode_sv39, 16'h5, 64'h3_0020, 44'h77777, flags_gx, 0, 0,
                miss_no, 64'h7777_7020, 0);
        add_row(priv_s, mode_sv39, 16'h1, 64'h1_0004, 44'h0abcd, flags_sx, 0, 0,
                miss_no, 64'h0abc_d004, 0);
        // errors
        add_row(priv_s, mode_sv39, 16'h1, 64'h0000_0040_0000_0000, 44'h0, flags_sx, 0, 0,
                miss_no, 64'h0, 1);
        add_row(priv_u, mode_sv39, 16'h1, 64'hffff_ff00_0000_0000, 44'h0, flags_sx, 0, 0,
                miss_no, 64'h0, 1);
        add_row(priv_s, mode_sv39, 16'h1, 64'h4_0000, 44'h11111, flags_nx, 0, 0,
                miss_yes, 64'h1111_1000, 1);
        add_row(priv_s, mode_sv39, 16'h1, 64'h4_0abc, 44'h11111, flags_nx, 0, 0,
                miss_no, 64'h1111_1abc, 1);
        add_row(priv_s, mode_sv39, 16'h1, 64'h5_0000, 44'h22222, flags_ux, 0, 0,
                miss_yes, 64'h2222_2000, 1);
        add_row(priv_u, mode_sv39, 16'h1, 64'h1_0200, 44'h0abcd, flags_sx, 0, 0,
                miss_no, 64'h0abc_d200, 1);
        add_row(priv_u, mode_sv39, 16'h1, 64'h5_0004, 44'h22222, flags_ux, 0, 0,
                miss_no, 64'h2222_2004, 0);
        add_row(priv_s, mode_sv39, 16'h1, 64'h6_0000, 44'h33333, flags_sx, 1, 0,
                miss_yes, 64'h3333_3000, 1);
        add_row(priv_s, mode_sv39, 16'h1, 64'h6_0010, 44'h33333, flags_sx, 0, 0,
                miss_yes, 64'h3333_3010, 0);
        // nine pages into eight ways, then a second pass and an sfence
        for (int k = 0; k < 9; k++) begin
            add_row(priv_s, mode_sv39, 16'h7, 64'h10_0018 + (64'(k) << 12),
                    44'h4_0000 + 44'(k), flags_sx, 0, k == 0,
                    miss_yes, 64'h4000_0018 + (64'(k) << 12), 0);
        end
        for (int k = 0; k < 9; k++) begin
            add_row(priv_s, mode_sv39, 16'h7, 64'h10_0020 + (64'(k) << 12),
                    44'h4_0000 + 44'(k), flags_sx, 0, 0,
                    miss_any, 64'h4000_0020 + (64'(k) << 12), 0);
        end
        for (int k = 0; k < 9; k += 4) begin
            add_row(priv_s, mode_sv39, 16'h7, 64'h10_0030 + (64'(k) << 12),
                    44'h4_0000 + 44'(k), flags_sx, 0, k == 0,
                    miss_yes, 64'h4000_0030 + (64'(k) << 12), 0);
        end
    endfunction

    // **************************************************************************
    // fetch driver
    // **************************************************************************

    task automatic apply_row(input int r);
        fetch_row_t row;
        logic       accepted;
        logic       miss_seen;
        row = rows[r];
        @(negedge clk);
        if (row.sflush) begin
            mmu_fifo_valid   = 1'b0;
            sflush_vma_valid = 1'b1;
            @(negedge clk);
            sflush_vma_valid = 1'b0;
        end
        current_priv_status = row.priv;
        satp_mode           = row.mode;
        satp_asid           = row.asid;
        vaddr               = row.va;
        resp_pte            = row.pte;
        resp_err            = row.pte_err;
        mmu_fifo_valid      = 1'b1;
        accepted            = 1'b0;
        miss_seen           = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            if (immu_miss_valid) begin
                miss_seen = 1'b1;
                check_value("miss_vaddr", miss_vaddr, row.va);
            end
            accepted = mmu_fifo_valid && mmu_fifo_ready;
        end
        pending_q.push_back(r);
        if (row.exp_miss == miss_any) begin
            if (miss_seen) begin
                any_misses++;
            end
        end else begin
            check_value("immu_miss_valid", 64'(miss_seen), 64'(row.exp_miss));
        end
    endtask

    initial begin
        seed                = $urandom(32'h75b2);
        current_priv_status = priv_m;
        satp_mode           = satp_mode_bare;
        satp_asid           = '0;
        flush_flag          = 1'b0;
        sflush_vma_valid    = 1'b0;
        mmu_fifo_valid      = 1'b0;
        vaddr               = '0;
        resp_pte            = '0;
        resp_err            = 1'b0;
        results_seen        = 0;
        any_misses          = 0;
        build_table();
        row_count = rows.size();
        wait (rst_n === 1'b1);
        for (int r = 0; r < row_count; r++) begin
            apply_row(r);
        end
        @(negedge clk);
        mmu_fifo_valid = 1'b0;
        while (results_seen < row_count) begin
            @(posedge clk);
        end
        // nine pages cannot all stay in eight ways
        if (any_misses == 0) begin
            fail_run("no page of the second pass missed after nine pages were filled");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    // **************************************************************************
    // l2 tlb model and icache side
    // **************************************************************************

    initial begin
        int   delay;
        logic taken;
        immu_miss_ready = 1'b0;
        pte_valid       = 1'b0;
        pte             = '0;
        pte_error       = 1'b0;
        forever begin
            @(posedge clk);
            if (immu_miss_valid) begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(posedge clk);
                @(negedge clk);
                immu_miss_ready = 1'b1;
                @(negedge clk);
                immu_miss_ready = 1'b0;
                delay = $urandom_range(5, 0);
                repeat (delay) @(negedge clk);
                pte       = resp_pte;
                pte_error = resp_err;
                pte_valid = 1'b1;
                taken     = 1'b0;
                while (!taken) begin
                    @(posedge clk);
                    taken = pte_ready;
                end
                @(negedge clk);
                pte_valid = 1'b0;
                pte_error = 1'b0;
            end
        end
    end

    // random stalls, roughly one cycle in four
    initial begin
        paddr_ready = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            paddr_ready = ($urandom_range(3, 0) != 0);
        end
    end

    initial begin
        int idx;
        forever begin
            @(posedge clk);
            if (rst_n && paddr_valid && paddr_ready) begin
                if (pending_q.size() == 0) begin
                    fail_run("a result came out with no fetch outstanding");
                end
                idx = pending_q.pop_front();
                check_value("paddr", paddr, rows[idx].exp_pa);
                check_value("paddr_error", 64'(paddr_error), 64'(rows[idx].exp_err));
                results_seen++;
            end
        end
    end

    initial begin
        wait (row_count > 0);
        repeat (row_count * cycles_per_row) @(posedge clk);
        fail_run("timeout: the results did not all arrive in time");
    end

endmodule

// File: design/immu.sv
`timescale 1ns/1ps

module immu
    import immu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // csr state
    input  priv_t       current_priv_status,
    input  logic [3:0]  satp_mode,
    input  asid_t       satp_asid,
    // flushes
    input  logic        flush_flag,
    input  logic        sflush_vma_valid,
    // l2 tlb
    output logic        immu_miss_valid,
    input  logic        immu_miss_ready,
    output vaddr_t      miss_vaddr,
    input  logic        pte_valid,
    output logic        pte_ready,
    input  pte_t        pte,
    input  logic        pte_error,
    // fetch fifo
    input  logic        mmu_fifo_valid,
    output logic        mmu_fifo_ready,
    input  vaddr_t      vaddr,
    // icache
    output logic        paddr_valid,
    input  logic        paddr_ready,
    output paddr_t      paddr,
    output logic        paddr_error
);

    logic miss_req;
    logic out_free;
    logic refill_done;
    logic fill_en;
    logic hit_used;
    way_t victim_way;

    tlb_lookup_if lookup_if ();

    assign miss_vaddr = vaddr;

    tlb_array tlb_array_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .sflush_vma_valid (sflush_vma_valid),
        .fill_en          (fill_en),
        .victim_way       (victim_way),
        .pte              (pte),
        .lookup           (lookup_if.storage)
    );

    plru_tree plru_tree_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .hit_used   (hit_used),
        .fill_en    (fill_en),
        .lookup     (lookup_if.observer),
        .victim_way (victim_way)
    );

    refill_ctrl refill_ctrl_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_flag      (flush_flag),
        .miss_req        (miss_req),
        .out_free        (out_free),
        .immu_miss_ready (immu_miss_ready),
        .pte_valid       (pte_valid),
        .pte_error       (pte_error),
        .immu_miss_valid (immu_miss_valid),
        .pte_ready       (pte_ready),
        .refill_done     (refill_done),
        .fill_en         (fill_en)
    );

    translate_stage translate_stage_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .flush_flag          (flush_flag),
        .current_priv_status (current_priv_status),
        .satp_mode           (satp_mode),
        .satp_asid           (satp_asid),
        .mmu_fifo_valid      (mmu_fifo_valid),
        .vaddr               (vaddr),
        .paddr_ready         (paddr_ready),
        .refill_done         (refill_done),
        .pte                 (pte),
        .pte_error           (pte_error),
        .lookup              (lookup_if.requester),
        .mmu_fifo_ready      (mmu_fifo_ready),
        .miss_req            (miss_req),
        .out_free            (out_free),
        .hit_used            (hit_used),
        .paddr_valid         (paddr_valid),
        .paddr               (paddr),
        .paddr_error         (paddr_error)
    );

endmodule

// File: design/immu_pkg.sv
package immu_pkg;

    // **************************************************************************
    // sizes
    // **************************************************************************

    localparam int tlb_ways         = 8;
    localparam int page_offset_bits = 12;
    localparam int va_bits          = 39;

    // **************************************************************************
    // types
    // **************************************************************************

    typedef logic [63:0]                         vaddr_t;
    typedef logic [63:0]                         paddr_t;
    typedef logic [va_bits-page_offset_bits-1:0] vpn_t;
    typedef logic [43:0]                         ppn_t;
    typedef logic [15:0]                         asid_t;
    typedef logic [127:0]                        pte_t;
    typedef logic [1:0]                          priv_t;
    typedef logic [tlb_ways-1:0]                 way_t;

    // miss handling toward the l2 tlb
    typedef enum logic [1:0] {
        refill_idle   = 2'h0,
        refill_submit = 2'h1,
        refill_wait   = 2'h3
    } refill_state_t;

    // **************************************************************************
    // csr codes
    // **************************************************************************

    localparam logic [3:0] satp_mode_bare = 4'h0;
    localparam priv_t      priv_m         = 2'd3;

    // **************************************************************************
    // l2 tlb response word
    // **************************************************************************

    // vpn sits in [57:31]
    localparam int pte_vpn_lsb  = 31;
    // ppn sits in [111:68]
    localparam int pte_ppn_lsb  = 68;
    localparam int pte_g_bit    = 63;
    localparam int pte_u_bit    = 62;
    localparam int pte_x_bit    = 61;
    // asid sits in [127:112]
    localparam int pte_asid_lsb = 112;

endpackage

// File: design/plru_tree.sv
`timescale 1ns/1ps

module plru_tree
    import immu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             hit_used,
    input  logic             fill_en,
    tlb_lookup_if.observer   lookup,
    output way_t             victim_way
);

    // node 0 is the root, 1..2 the middle level, 3..6 the leaves
    logic [tlb_ways-2:0] tree_q;
    logic [2:0]          touch_idx;
    logic [2:0]          victim_idx;

    function automatic logic [2:0] way_index(input way_t w);
        logic [2:0] idx;
        idx = '0;
        for (int i = 0; i < tlb_ways; i++) begin
            if (w[i]) begin
                idx = 3'(i);
            end
        end
        return idx;
    endfunction

    assign touch_idx = fill_en ? way_index(victim_way) : way_index(lookup.hit_way);

    // point every node on the path away from the touched way
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tree_q <= '0;
        end else if (fill_en || hit_used) begin
            tree_q[0]                   <= ~touch_idx[2];
            tree_q[1 + touch_idx[2]]    <= ~touch_idx[1];
            tree_q[3 + touch_idx[2:1]]  <= ~touch_idx[0];
        end
    end

    // bit set means the victim is in the upper half
    always_comb begin
        victim_idx[2] = tree_q[0];
        victim_idx[1] = tree_q[1 + victim_idx[2]];
        victim_idx[0] = tree_q[3 + victim_idx[2:1]];
    end

    assign victim_way = way_t'(1) << victim_idx;

    victim_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(victim_way));

endmodule

// File: design/refill_ctrl.sv
`timescale 1ns/1ps

module refill_ctrl
    import immu_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic flush_flag,
    input  logic miss_req,
    input  logic out_free,
    input  logic immu_miss_ready,
    input  logic pte_valid,
    input  logic pte_error,
    output logic immu_miss_valid,
    output logic pte_ready,
    output logic refill_done,
    output logic fill_en
);

    refill_state_t state_q;
    refill_state_t state_d;

    // **************************************************************************
    // fsm
    // **************************************************************************

    always_comb begin
        state_d = state_q;
        case (state_q)
            refill_idle: begin
                if (miss_req) begin
                    state_d = refill_submit;
                end
            end
            refill_submit: begin
                if (immu_miss_ready) begin
                    state_d = refill_wait;
                end
            end
            refill_wait: begin
                if (refill_done) begin
                    state_d = refill_idle;
                end
            end
            default: begin
                state_d = refill_idle;
            end
        endcase
        // flush drops the refill in any state
        if (flush_flag) begin
            state_d = refill_idle;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= refill_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // **************************************************************************
    // handshakes
    // **************************************************************************

    assign immu_miss_valid = (state_q == refill_submit);
    // hold the response off while the output register is stalled
    assign pte_ready       = (state_q == refill_wait) && out_free;
    assign refill_done     = pte_valid && pte_ready;
    assign fill_en         = refill_done && !pte_error;

    pte_ready_state_a: assert property (@(posedge clk) disable iff (!rst_n)
        pte_ready |-> state_q == refill_wait);

endmodule

// File: design/tlb_array.sv
`timescale 1ns/1ps

module tlb_array
    import immu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sflush_vma_valid,
    input  logic             fill_en,
    input  way_t             victim_way,
    input  pte_t             pte,
    tlb_lookup_if.storage    lookup
);

    vpn_t  tag_q  [tlb_ways];
    ppn_t  ppn_q  [tlb_ways];
    asid_t asid_q [tlb_ways];
    way_t  g_q;
    way_t  u_q;
    way_t  x_q;
    way_t  valid_q;
    way_t  hit_way;
    ppn_t  sel_ppn;
    logic  sel_user;
    logic  sel_exec;
    logic  sel_global;

    // **************************************************************************
    // storage
    // **************************************************************************

    // sfence wins over a fill in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (sflush_vma_valid) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q <= valid_q | victim_way;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < tlb_ways; i++) begin
            if (fill_en && victim_way[i]) begin
                tag_q[i]  <= pte[pte_vpn_lsb +: $bits(vpn_t)];
                ppn_q[i]  <= pte[pte_ppn_lsb +: $bits(ppn_t)];
                asid_q[i] <= pte[pte_asid_lsb +: $bits(asid_t)];
                g_q[i]    <= pte[pte_g_bit];
                u_q[i]    <= pte[pte_u_bit];
                x_q[i]    <= pte[pte_x_bit];
            end
        end
    end

    // **************************************************************************
    // compare and select
    // **************************************************************************

    always_comb begin
        for (int i = 0; i < tlb_ways; i++) begin
            hit_way[i] = valid_q[i] && (tag_q[i] == lookup.vpn) &&
                         ((asid_q[i] == lookup.asid) || g_q[i]);
        end
    end

    // and-or mux, at most one way is set
    always_comb begin
        sel_ppn    = '0;
        sel_user   = 1'b0;
        sel_exec   = 1'b0;
        sel_global = 1'b0;
        for (int i = 0; i < tlb_ways; i++) begin
            sel_ppn    = sel_ppn | (ppn_q[i] & {$bits(ppn_t){hit_way[i]}});
            sel_user   = sel_user | (u_q[i] & hit_way[i]);
            sel_exec   = sel_exec | (x_q[i] & hit_way[i]);
            sel_global = sel_global | (g_q[i] & hit_way[i]);
        end
    end

    assign lookup.hit         = |hit_way;
    assign lookup.hit_way     = hit_way;
    assign lookup.ppn         = sel_ppn;
    assign lookup.user        = sel_user;
    assign lookup.exec        = sel_exec;
    assign lookup.global_page = sel_global;

    // fills happen only on a miss, so a page never lands in two ways
    hit_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(hit_way));

endmodule

// File: design/tlb_lookup_if.sv
`timescale 1ns/1ps

interface tlb_lookup_if import immu_pkg::*; ();

    // lookup key
    vpn_t  vpn;
    asid_t asid;

    // result of the compare
    logic  hit;
    way_t  hit_way;
    ppn_t  ppn;
    logic  user;
    logic  exec;
    logic  global_page;

    modport storage (
        input  vpn, asid,
        output hit, hit_way, ppn, user, exec, global_page
    );

    modport requester (
        output vpn, asid,
        input  hit, ppn, user, exec, global_page
    );

    modport observer (
        input  hit_way
    );

endinterface

// File: design/translate_stage.sv
`timescale 1ns/1ps

module translate_stage
    import immu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush_flag,
    input  priv_t             current_priv_status,
    input  logic [3:0]        satp_mode,
    input  asid_t             satp_asid,
    input  logic              mmu_fifo_valid,
    input  vaddr_t            vaddr,
    input  logic              paddr_ready,
    input  logic              refill_done,
    input  pte_t              pte,
    input  logic              pte_error,
    tlb_lookup_if.requester   lookup,
    output logic              mmu_fifo_ready,
    output logic              miss_req,
    output logic              out_free,
    output logic              hit_used,
    output logic              paddr_valid,
    output paddr_t            paddr,
    output logic              paddr_error
);

    logic   bypass;
    logic   canonical;
    logic   accept;
    ppn_t   page_ppn;
    logic   page_user;
    logic   page_exec;
    paddr_t paddr_d;
    logic   error_d;

    // **************************************************************************
    // decision
    // **************************************************************************

    assign bypass    = (current_priv_status == priv_m) || (satp_mode == satp_mode_bare);
    assign canonical = (vaddr[63:va_bits-1] == {(65-va_bits){vaddr[va_bits-1]}});

    assign lookup.vpn  = vaddr[va_bits-1:page_offset_bits];
    assign lookup.asid = satp_asid;

    assign out_free       = !paddr_valid || paddr_ready;
    assign miss_req       = mmu_fifo_valid && !bypass && canonical && !lookup.hit;
    assign mmu_fifo_ready = out_free && (bypass || !canonical || lookup.hit || refill_done);
    assign accept         = mmu_fifo_valid && mmu_fifo_ready;
    assign hit_used       = accept && !bypass && canonical && lookup.hit;

    // the entry is not in the array yet on the refill cycle
    assign page_ppn  = refill_done ? pte[pte_ppn_lsb +: $bits(ppn_t)] : lookup.ppn;
    assign page_user = refill_done ? pte[pte_u_bit] : lookup.user;
    assign page_exec = refill_done ? pte[pte_x_bit] : lookup.exec;

    always_comb begin
        if (bypass) begin
            paddr_d = vaddr;
            error_d = 1'b0;
        end else if (!canonical) begin
            paddr_d = '0;
            error_d = 1'b1;
        end else begin
            paddr_d = paddr_t'({page_ppn, vaddr[page_offset_bits-1:0]});
            // priv bit 0 is S, so S on a user page or U on a supervisor page faults
            error_d = !page_exec || (current_priv_status[0] == page_user) ||
                      (refill_done && pte_error);
        end
    end

    // **************************************************************************
    // output register
    // **************************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            paddr_valid <= 1'b0;
        end else if (flush_flag) begin
            paddr_valid <= 1'b0;
        end else if (out_free) begin
            paddr_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            paddr       <= paddr_d;
            paddr_error <= error_d;
        end
    end

    stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        paddr_valid && !paddr_ready && !flush_flag |=>
            paddr_valid && $stable(paddr) && $stable(paddr_error));

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module immu_tb -f all.f -o immu_sim

./obj_dir/immu_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "simulation ended without a pass"
    exit 1
fi
